// File: Bender.yml
package:
  name: cpu16

sources:
  - files:
      - verilog/cpu_pkg.sv
      - verilog/ctrl_if.sv
      - verilog/control_unit.sv
      - verilog/alu.sv
      - verilog/register_file.sv
      - verilog/hazard_detect.sv
      - verilog/datapath.sv
      - verilog/cpu_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/cpu_properties.sv
      - test/cpu_tb.sv

// File: src.f
verilog/cpu_pkg.sv
verilog/ctrl_if.sv
verilog/control_unit.sv
verilog/alu.sv
verilog/register_file.sv
verilog/hazard_detect.sv
verilog/datapath.sv
verilog/cpu_top.sv
test/tb_clock.sv
test/cpu_properties.sv
test/cpu_tb.sv

// File: test/cpu_properties.sv
`timescale 1ns/1ns

module cpu_properties (
	input logic clk,
	input logic rst,
	input logic data_read,
	input logic data_write,
	input logic output_valid,
	input logic is_halted
);

	// one data access per cycle
	strobes_exclusive: assert property (
		@(posedge clk) disable iff (rst) !(data_read && data_write)
	) else $error("data_read and data_write high in the same cycle");

	// halt holds until the next reset
	halt_sticky: assert property (
		@(posedge clk) disable iff (rst) is_halted |=> is_halted
	) else $error("is_halted fell without a reset");

	quiet_after_halt: assert property (
		@(posedge clk) disable iff (rst) is_halted |-> !output_valid
	) else $error("output_valid high while halted");

endmodule

bind cpu_top cpu_properties props0 (
	.clk(clk),
	.rst(rst),
	.data_read(data_read),
	.data_write(data_write),
	.output_valid(output_valid),
	.is_halted(is_halted)
);

// File: test/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb;
	import cpu_pkg::*;

	localparam logic [15:0] start_pc = 16'h0000;
	localparam int tests_per_kind = 6;
	localparam int num_tests = 4 * tests_per_kind;
	localparam int blocks = 24;
	// at most three words per block plus the closing HLT
	localparam int max_len = 3 * blocks + 1;
	localparam int watchdog_cycles = num_tests * max_len * 8;
	localparam logic [15:0] hlt_word = {op_rtype, 6'd0, fn_hlt};

	logic clk;
	logic rst;
	logic inst_read;
	logic [15:0] inst_address;
	logic [15:0] inst_data;
	logic data_read;
	logic data_write;
	logic [15:0] data_address;
	logic [15:0] data_wdata;
	logic [15:0] data_rdata;
	logic [15:0] num_inst;
	logic [15:0] output_port;
	logic output_valid;
	logic is_halted;

	logic [15:0] imem [256];
	logic [15:0] dmem [65536];
	logic [15:0] model_mem [65536];
	logic [31:0] lfsr_state;
	logic [15:0] prog [$];
	int starts [$];
	int carriers [$];
	int jumpers [$];
	logic [1:0] last_dest;
	logic [15:0] exp_wwd [$];
	logic [15:0] exp_addr [$];
	logic [15:0] exp_data [$];
	int exp_count;
	int wwd_seen;
	int stores_seen;
	logic wwd_pending;
	int errors;
	int failed_tests;

	tb_clock #(.period(8)) clock0 (.clk(clk));

	cpu_top #(.reset_pc(start_pc)) dut0 (
		.clk(clk),
		.rst(rst),
		.inst_read(inst_read),
		.inst_address(inst_address),
		.inst_data(inst_data),
		.data_read(data_read),
		.data_write(data_write),
		.data_address(data_address),
		.data_wdata(data_wdata),
		.data_rdata(data_rdata),
		.num_inst(num_inst),
		.output_port(output_port),
		.output_valid(output_valid),
		.is_halted(is_halted)
	);

	// both memories answer in the same cycle
	assign inst_data = imem[inst_address[7:0]];
	// data memory only answers while the read strobe is up
	assign data_rdata = data_read ? dmem[data_address] : 16'hxxxx;

	// galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic next_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out) begin
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		end
		return out;
	endfunction

	function automatic logic [31:0] draw(int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], next_bit()};
		end
		return v;
	endfunction

	function automatic logic [15:0] rtype(logic [1:0] rs, logic [1:0] rt, logic [1:0] rd,
			funct_t fn);
		return {op_rtype, rs, rt, rd, fn};
	endfunction

	function automatic logic [15:0] itype(opcode_t op, logic [1:0] rs, logic [1:0] rt,
			logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] fill(logic [15:0] a);
		return {a[7:0], a[15:8]} ^ 16'h3c5a;
	endfunction

	// one nibble per selector value in each test kind's block mix
	// 0 rtype, 1 adi, 2 ori, 3 lhi, 4 wwd, 5 lwd, 6 swd, 7 branch, 8 jmp/jal, 9 jpr/jrl
	function automatic logic [3:0] block_code(int kind, logic [2:0] sel);
		logic [31:0] mix;
		case (kind)
			0: mix = 32'h4043_2100;
			1: mix = 32'h5414_5665;
			2: mix = 32'h4620_4510;
			default: mix = 32'h4714_6987;
		endcase
		return mix[sel * 4 +: 4];
	endfunction

	task automatic add_block(int kind);
		logic [1:0] rs;
		logic [1:0] rt;
		logic [1:0] rd;
		logic [7:0] imm;
		logic [3:0] code;
		rs = 2'(draw(2));
		rt = 2'(draw(2));
		rd = 2'(draw(2));
		imm = 8'(draw(8));
		code = block_code(kind, 3'(draw(3)));
		// chain onto the previous result so decode has to stall
		if (kind == 2) begin
			rs = last_dest;
			if (draw(1) == 1) begin
				rt = last_dest;
			end
		end
		starts.push_back(prog.size());
		case (code)
			0: begin
				prog.push_back(rtype(rs, rt, rd, funct_t'(6'(draw(3)))));
				last_dest = rd;
			end
			1, 2, 3, 5: begin
				case (code)
					1: prog.push_back(itype(op_adi, rs, rt, imm));
					2: prog.push_back(itype(op_ori, rs, rt, imm));
					3: prog.push_back(itype(op_lhi, rs, rt, imm));
					default: prog.push_back(itype(op_lwd, rs, rt, imm));
				endcase
				last_dest = rt;
			end
			4: prog.push_back(rtype(rs, 2'd0, 2'd0, fn_wwd));
			6: prog.push_back(itype(op_swd, rs, rt, imm));
			7: begin
				carriers.push_back(prog.size());
				jumpers.push_back(prog.size());
				prog.push_back(itype(opcode_t'(4'(draw(2))), rs, rt, 8'h00));
			end
			8: begin
				carriers.push_back(prog.size());
				jumpers.push_back(prog.size());
				prog.push_back({(draw(1) == 1) ? op_jal : op_jmp, 12'h000});
				last_dest = 2'd2;
			end
			default: begin
				// load the target into rs, then jump through it
				prog.push_back(itype(op_lhi, 2'd0, rs, 8'h00));
				carriers.push_back(prog.size());
				prog.push_back(itype(op_ori, rs, rs, 8'h00));
				jumpers.push_back(prog.size());
				prog.push_back(rtype(rs, 2'd0, 2'd0, (draw(1) == 1) ? fn_jrl : fn_jpr));
				last_dest = 2'd2;
			end
		endcase
	endtask

	// targets land on a later block start and never inside a block
	task automatic patch_targets();
		int j;
		int k;
		int s;
		logic [15:0] w;
		for (j = 0; j < carriers.size(); j++) begin
			k = 0;
			while (starts[k] <= jumpers[j]) begin
				k++;
			end
			k = k + int'(draw(2));
			if (k >= starts.size()) begin
				k = starts.size() - 1;
			end
			s = starts[k];
			w = prog[carriers[j]];
			case (w[15:12])
				op_ori: w[7:0] = 8'(s);
				op_jmp, op_jal: w[11:0] = 12'(s);
				default: w[7:0] = 8'(s - jumpers[j] - 1);
			endcase
			prog[carriers[j]] = w;
		end
	endtask

	task automatic build_program(int kind);
		int b;
		prog.delete();
		starts.delete();
		carriers.delete();
		jumpers.delete();
		last_dest = 2'd0;
		for (b = 0; b < blocks; b++) begin
			add_block(kind);
		end
		starts.push_back(prog.size());
		prog.push_back(hlt_word);
		patch_targets();
		for (b = 0; b < 256; b++) begin
			imem[8'(b)] = (b < prog.size()) ? prog[b] : hlt_word;
		end
	endtask

	task automatic load_memories();
		int a;
		for (a = 0; a < 65536; a++) begin
			dmem[16'(a)] = fill(16'(a));
			model_mem[16'(a)] = fill(16'(a));
		end
	endtask

	// instruction-set model stepping one instruction at a time
	task automatic run_model();
		logic [15:0] r [4];
		logic [15:0] pc;
		logic [15:0] next;
		logic [15:0] inst;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] sext;
		logic done;
		int steps;
		r = '{16'h0, 16'h0, 16'h0, 16'h0};
		pc = start_pc;
		done = 1'b0;
		steps = 0;
		exp_wwd.delete();
		exp_addr.delete();
		exp_data.delete();
		while (!done && steps < 4 * max_len) begin
			inst = imem[pc[7:0]];
			a = r[inst[11:10]];
			b = r[inst[9:8]];
			sext = {{8{inst[7]}}, inst[7:0]};
			next = pc + 16'd1;
			steps++;
			case (inst[15:12])
				op_bne: if (a != b) next = pc + 16'd1 + sext;
				op_beq: if (a == b) next = pc + 16'd1 + sext;
				op_bgz: if (!a[15] && a != 16'd0) next = pc + 16'd1 + sext;
				op_blz: if (a[15]) next = pc + 16'd1 + sext;
				op_adi: r[inst[9:8]] = a + sext;
				op_ori: r[inst[9:8]] = a | {8'h00, inst[7:0]};
				op_lhi: r[inst[9:8]] = {inst[7:0], 8'h00};
				op_lwd: r[inst[9:8]] = model_mem[a + sext];
				op_swd: begin
					model_mem[a + sext] = b;
					exp_addr.push_back(a + sext);
					exp_data.push_back(b);
				end
				op_jmp: next = {pc[15:12], inst[11:0]};
				op_jal: begin
					r[2] = pc + 16'd1;
					next = {pc[15:12], inst[11:0]};
				end
				op_rtype: begin
					case (inst[5:0])
						fn_add: r[inst[7:6]] = a + b;
						fn_sub: r[inst[7:6]] = a - b;
						fn_and: r[inst[7:6]] = a & b;
						fn_orr: r[inst[7:6]] = a | b;
						fn_not: r[inst[7:6]] = ~a;
						fn_tcp: r[inst[7:6]] = ~a + 16'd1;
						fn_shl: r[inst[7:6]] = {a[14:0], 1'b0};
						fn_shr: r[inst[7:6]] = {a[15], a[15:1]};
						fn_jpr: next = a;
						fn_jrl: begin
							r[2] = pc + 16'd1;
							next = a;
						end
						fn_wwd: exp_wwd.push_back(a);
						fn_hlt: done = 1'b1;
						default: ;
					endcase
				end
				default: ;
			endcase
			pc = next;
		end
		exp_count = steps;
	endtask

	// output_port settles one edge after the output_valid cycle
	task automatic observe();
		if (wwd_pending) begin
			assert (output_port == exp_wwd[wwd_seen]) else begin
				$display("[ERROR] %0t: output port %h, expected %h", $time, output_port,
					exp_wwd[wwd_seen]);
				errors++;
			end
			wwd_seen++;
			wwd_pending = 1'b0;
		end
		if (output_valid) begin
			assert (wwd_seen < exp_wwd.size()) else begin
				$display("unexpected output pulse at %0t, beyond the %0d the program makes",
					$time, exp_wwd.size());
				errors++;
			end
			wwd_pending = 1'b1;
		end
		if (data_write) begin
			assert (data_address == exp_addr[stores_seen] &&
					data_wdata == exp_data[stores_seen]) else begin
				$display("[ERROR] %0t: store %h to %h, expected %h to %h", $time, data_wdata,
					data_address, exp_data[stores_seen], exp_addr[stores_seen]);
				errors++;
			end
			dmem[data_address] = data_wdata;
			stores_seen++;
		end
	endtask

	task automatic run_test(int kind, int index);
		int errors_before;
		logic [15:0] halt_count;
		errors_before = errors;
		build_program(kind);
		load_memories();
		run_model();
		wwd_seen = 0;
		stores_seen = 0;
		wwd_pending = 1'b0;
		rst = 1'b1;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		assert (!is_halted && !output_valid && inst_read && !data_read && !data_write &&
				num_inst == 16'd0 && output_port == 16'd0) else begin
			$display("[ERROR] %0t: outputs not in their reset state", $time);
			errors++;
		end
		while (!is_halted) begin
			@(negedge clk);
			observe();
		end
		assert (num_inst == 16'(exp_count)) else begin
			$display("[ERROR] %0t: %0d instructions retired, expected %0d", $time, num_inst,
				exp_count);
			errors++;
		end
		halt_count = num_inst;
		repeat (12) begin
			@(negedge clk);
			observe();
			assert (!inst_read && !data_write && !output_valid && num_inst == halt_count)
				else begin
				$display("processor still active after halt at %0t", $time);
				errors++;
			end
		end
		assert (wwd_seen == exp_wwd.size() && stores_seen == exp_addr.size()) else begin
			$display("test %0d lost activity: %0d of %0d outputs, %0d of %0d stores", index,
				wwd_seen, exp_wwd.size(), stores_seen, exp_addr.size());
			errors++;
		end
		if (errors != errors_before) begin
			failed_tests++;
		end
		$display("test %0d kind %0d: %s, %0d retired, %0d outputs, %0d stores", index, kind,
			(errors == errors_before) ? "ok" : "FAILED", exp_count, exp_wwd.size(),
			exp_addr.size());
	endtask

	initial begin
		int kind;
		int t;
		rst = 1'b1;
		errors = 0;
		failed_tests = 0;
		lfsr_state = 32'hc2ad_ef0d;
		for (t = 0; t < 256; t++) begin
			imem[8'(t)] = hlt_word;
		end
		load_memories();
		// kinds are alu, memory, dependent chains and control flow
		for (kind = 0; kind < 4; kind++) begin
			for (t = 0; t < tests_per_kind; t++) begin
				run_test(kind, kind * tests_per_kind + t);
			end
		end
		$display("%0d tests run, %0d failed, %0d errors", num_tests, failed_tests, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the processor never halted",
			watchdog_cycles);
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
	parameter int period = 8
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ns

module alu (
	input logic [cpu_pkg::word_size-1:0] a,
	input logic [cpu_pkg::word_size-1:0] b,
	input cpu_pkg::alu_op_t op,
	output logic [cpu_pkg::word_size-1:0] result,
	output logic bcond
);
	import cpu_pkg::*;

	always_comb begin
		result = '0;
		bcond = 1'b0;
		case (op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_orr: result = a | b;
			alu_not: result = ~a;
			// two's complement negate
			alu_tcp: result = ~a + 1'b1;
			alu_shl: result = {a[word_size-2:0], 1'b0};
			alu_shr: result = {a[word_size-1], a[word_size-1:1]};
			alu_pass_b: result = b;
			alu_bne: bcond = (a != b);
			alu_beq: bcond = (a == b);
			alu_bgz: bcond = !a[word_size-1] && (a != '0);
			alu_blz: bcond = a[word_size-1];
			default: result = '0;
		endcase
	end

endmodule

// File: verilog/control_unit.sv
`timescale 1ns/1ns

module control_unit (
	input logic [cpu_pkg::word_size-1:0] inst,
	ctrl_if.decoder ctrl
);
	import cpu_pkg::*;

	opcode_t opcode;
	funct_t funct;

	assign opcode = opcode_t'(inst[15:12]);
	assign funct = funct_t'(inst[5:0]);

	always_comb begin
		// bubble unless the encoding is recognised
		ctrl.alu_op = alu_add;
		ctrl.alu_src_imm = 1'b0;
		ctrl.imm_zero_ext = 1'b0;
		ctrl.mem_read = 1'b0;
		ctrl.mem_write = 1'b0;
		ctrl.reg_write = 1'b0;
		ctrl.wb_sel = wb_alu;
		ctrl.dest = inst[9:8];
		ctrl.uses_rs = 1'b0;
		ctrl.uses_rt = 1'b0;
		ctrl.branch_kind = br_none;
		ctrl.is_wwd = 1'b0;
		ctrl.is_halt = 1'b0;
		case (opcode)
			op_rtype: begin
				case (funct)
					fn_add, fn_sub, fn_and, fn_orr, fn_not, fn_tcp, fn_shl, fn_shr: begin
						ctrl.alu_op = alu_op_t'(funct[3:0]);
						ctrl.reg_write = 1'b1;
						ctrl.dest = inst[7:6];
						ctrl.uses_rs = 1'b1;
						// unary ops leave rt alone
						ctrl.uses_rt = funct inside {fn_add, fn_sub, fn_and, fn_orr};
					end
					fn_jpr, fn_jrl: begin
						ctrl.branch_kind = br_jreg;
						ctrl.uses_rs = 1'b1;
						ctrl.reg_write = (funct == fn_jrl);
						ctrl.wb_sel = wb_pc;
						ctrl.dest = 2'd2;
					end
					fn_wwd: begin
						// rs passes through the adder, rt operand is zeroed
						ctrl.is_wwd = 1'b1;
						ctrl.uses_rs = 1'b1;
					end
					fn_hlt: ctrl.is_halt = 1'b1;
					default: ;
				endcase
			end
			op_adi, op_ori, op_lwd: begin
				ctrl.alu_op = (opcode == op_ori) ? alu_orr : alu_add;
				ctrl.alu_src_imm = 1'b1;
				ctrl.imm_zero_ext = (opcode == op_ori);
				ctrl.mem_read = (opcode == op_lwd);
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel = (opcode == op_lwd) ? wb_mem : wb_alu;
				ctrl.uses_rs = 1'b1;
			end
			op_lhi: begin
				ctrl.alu_op = alu_pass_b;
				ctrl.alu_src_imm = 1'b1;
				ctrl.imm_zero_ext = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel = wb_lhi;
			end
			op_swd: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write = 1'b1;
				ctrl.uses_rs = 1'b1;
				ctrl.uses_rt = 1'b1;
			end
			op_bne, op_beq, op_bgz, op_blz: begin
				ctrl.branch_kind = br_cond;
				ctrl.uses_rs = 1'b1;
				ctrl.uses_rt = opcode inside {op_bne, op_beq};
				case (opcode)
					op_bne: ctrl.alu_op = alu_bne;
					op_beq: ctrl.alu_op = alu_beq;
					op_bgz: ctrl.alu_op = alu_bgz;
					default: ctrl.alu_op = alu_blz;
				endcase
			end
			op_jmp, op_jal: begin
				ctrl.branch_kind = br_jump;
				ctrl.reg_write = (opcode == op_jal);
				ctrl.wb_sel = wb_pc;
				ctrl.dest = 2'd2;
			end
			default: ;
		endcase
	end

endmodule

// File: verilog/cpu_pkg.sv
package cpu_pkg;

	// data and address width
	localparam int word_size = 16;

	// instruction opcodes, bits 15 to 12
	typedef enum logic [3:0] {
		op_bne = 4'd0, op_beq = 4'd1, op_bgz = 4'd2, op_blz = 4'd3,
		op_adi = 4'd4, op_ori = 4'd5, op_lhi = 4'd6, op_lwd = 4'd7,
		op_swd = 4'd8, op_jmp = 4'd9, op_jal = 4'd10,
		op_rtype = 4'd15
	} opcode_t;

	// function codes of the R-type group, bits 5 to 0
	typedef enum logic [5:0] {
		fn_add = 6'd0, fn_sub = 6'd1, fn_and = 6'd2, fn_orr = 6'd3,
		fn_not = 6'd4, fn_tcp = 6'd5, fn_shl = 6'd6, fn_shr = 6'd7,
		fn_jpr = 6'd25, fn_jrl = 6'd26,
		fn_wwd = 6'd28, fn_hlt = 6'd29
	} funct_t;

	// first eight entries share their codes with fn_add .. fn_shr
	typedef enum logic [3:0] {
		alu_add = 4'd0, alu_sub = 4'd1, alu_and = 4'd2, alu_orr = 4'd3,
		alu_not = 4'd4, alu_tcp = 4'd5, alu_shl = 4'd6, alu_shr = 4'd7,
		alu_pass_b = 4'd8,
		alu_bne = 4'd9, alu_beq = 4'd10, alu_bgz = 4'd11, alu_blz = 4'd12
	} alu_op_t;

	// write-back source
	typedef enum logic [1:0] {
		wb_alu = 2'd0,
		wb_mem = 2'd1,
		wb_pc = 2'd2,
		wb_lhi = 2'd3
	} wb_sel_t;

	typedef enum logic [1:0] {
		br_none = 2'd0,
		br_cond = 2'd1,
		br_jump = 2'd2,
		br_jreg = 2'd3
	} branch_kind_t;

endpackage

// File: verilog/cpu_top.sv
`timescale 1ns/1ns

module cpu_top #(
	parameter logic [cpu_pkg::word_size-1:0] reset_pc = '0
) (
	input logic clk,
	input logic rst,
	output logic inst_read,
	output logic [cpu_pkg::word_size-1:0] inst_address,
	input logic [cpu_pkg::word_size-1:0] inst_data,
	output logic data_read,
	output logic data_write,
	output logic [cpu_pkg::word_size-1:0] data_address,
	output logic [cpu_pkg::word_size-1:0] data_wdata,
	input logic [cpu_pkg::word_size-1:0] data_rdata,
	output logic [cpu_pkg::word_size-1:0] num_inst,
	output logic [cpu_pkg::word_size-1:0] output_port,
	output logic output_valid,
	output logic is_halted
);
	import cpu_pkg::*;

	logic [word_size-1:0] decode_inst;

	ctrl_if ctrl_bus ();

	control_unit u_ctrl (
		.inst(decode_inst),
		.ctrl(ctrl_bus)
	);

	datapath #(
		.reset_pc(reset_pc)
	) u_datapath (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl_bus),
		.inst_data(inst_data),
		.inst_read(inst_read),
		.inst_address(inst_address),
		.decode_inst(decode_inst),
		.data_read(data_read),
		.data_write(data_write),
		.data_address(data_address),
		.data_wdata(data_wdata),
		.data_rdata(data_rdata),
		.num_inst(num_inst),
		.output_port(output_port),
		.output_valid(output_valid),
		.is_halted(is_halted)
	);

endmodule

// File: verilog/ctrl_if.sv
`timescale 1ns/1ns

interface ctrl_if;
	import cpu_pkg::*;

	alu_op_t alu_op;
	logic alu_src_imm;
	logic imm_zero_ext;
	logic mem_read;
	logic mem_write;
	logic reg_write;
	wb_sel_t wb_sel;
	logic [1:0] dest;
	logic uses_rs;
	logic uses_rt;
	branch_kind_t branch_kind;
	logic is_wwd;
	logic is_halt;

	modport decoder (
		output alu_op, alu_src_imm, imm_zero_ext, mem_read, mem_write, reg_write,
		output wb_sel, dest, uses_rs, uses_rt, branch_kind, is_wwd, is_halt
	);

	modport pipeline (
		input alu_op, alu_src_imm, imm_zero_ext, mem_read, mem_write, reg_write,
		input wb_sel, dest, uses_rs, uses_rt, branch_kind, is_wwd, is_halt
	);

endinterface

// File: verilog/datapath.sv
`timescale 1ns/1ns

module datapath #(
	parameter logic [cpu_pkg::word_size-1:0] reset_pc = '0
) (
	input logic clk,
	input logic rst,
	ctrl_if.pipeline ctrl,
	input logic [cpu_pkg::word_size-1:0] inst_data,
	output logic inst_read,
	output logic [cpu_pkg::word_size-1:0] inst_address,
	output logic [cpu_pkg::word_size-1:0] decode_inst,
	output logic data_read,
	output logic data_write,
	output logic [cpu_pkg::word_size-1:0] data_address,
	output logic [cpu_pkg::word_size-1:0] data_wdata,
	input logic [cpu_pkg::word_size-1:0] data_rdata,
	output logic [cpu_pkg::word_size-1:0] num_inst,
	output logic [cpu_pkg::word_size-1:0] output_port,
	output logic output_valid,
	output logic is_halted
);
	import cpu_pkg::*;

	// control carried from execute onward
	typedef struct packed {
		alu_op_t alu_op;
		logic alu_src_imm;
		logic mem_read;
		logic mem_write;
		logic reg_write;
		wb_sel_t wb_sel;
		logic [1:0] dest;
		branch_kind_t branch_kind;
		logic is_wwd;
		logic is_halt;
	} stage_ctrl_t;

	logic [word_size-1:0] pc;
	logic fd_valid;
	logic [word_size-1:0] fd_inst, fd_pc;
	logic de_valid;
	stage_ctrl_t de_c;
	logic [word_size-1:0] de_a, de_b, de_imm, de_pc;
	logic [11:0] de_jaddr;
	logic em_valid;
	stage_ctrl_t em_c;
	logic [word_size-1:0] em_result, em_b, em_link;
	logic mw_valid;
	stage_ctrl_t mw_c;
	logic [word_size-1:0] mw_result, mw_mem, mw_link;
	stage_ctrl_t dec_c;
	logic [word_size-1:0] read_out1, read_out2, alu_b, alu_result, target, wb_data;
	logic bcond, taken, stall, stop, wb_write;

	assign dec_c = '{
		alu_op: ctrl.alu_op,
		alu_src_imm: ctrl.alu_src_imm,
		mem_read: ctrl.mem_read,
		mem_write: ctrl.mem_write,
		reg_write: ctrl.reg_write,
		wb_sel: ctrl.wb_sel,
		dest: ctrl.dest,
		branch_kind: ctrl.branch_kind,
		is_wwd: ctrl.is_wwd,
		is_halt: ctrl.is_halt
	};

	register_file u_regs (
		.clk(clk),
		.rst(rst),
		.read1(fd_inst[11:10]),
		.read2(fd_inst[9:8]),
		.read_out1(read_out1),
		.read_out2(read_out2),
		.dest(mw_c.dest),
		.write_data(wb_data),
		.reg_write(wb_write)
	);

	hazard_detect u_hazard (
		.rs(fd_inst[11:10]),
		.rt(fd_inst[9:8]),
		.uses_rs(fd_valid && ctrl.uses_rs),
		.uses_rt(fd_valid && ctrl.uses_rt),
		.dest_ex(de_c.dest),
		.dest_mem(em_c.dest),
		.reg_write_ex(de_valid && de_c.reg_write),
		.reg_write_mem(em_valid && em_c.reg_write),
		.stall(stall)
	);

	assign alu_b = de_c.alu_src_imm ? de_imm : de_b;

	alu u_alu (
		.a(de_a),
		.b(alu_b),
		.op(de_c.alu_op),
		.result(alu_result),
		.bcond(bcond)
	);

	always_comb begin
		case (de_c.branch_kind)
			br_jump: target = {de_pc[word_size-1 -: 4], de_jaddr};
			br_jreg: target = de_a;
			default: target = de_pc + 1'b1 + de_imm;
		endcase
	end

	assign taken = de_valid && (de_c.branch_kind == br_jump || de_c.branch_kind == br_jreg ||
		(de_c.branch_kind == br_cond && bcond));
	// an HLT anywhere past decode shuts fetch off for good
	assign stop = (de_valid && de_c.is_halt) || (em_valid && em_c.is_halt) ||
		(mw_valid && mw_c.is_halt) || is_halted;

	// fetch
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= reset_pc;
			fd_valid <= 1'b0;
		end else if (taken) begin
			pc <= target;
			fd_valid <= 1'b0;
		end else if (stop) begin
			fd_valid <= 1'b0;
		end else if (!stall) begin
			pc <= pc + 1'b1;
			fd_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			fd_inst <= inst_data;
			fd_pc <= pc;
		end
	end

	// decode, a stall sends a bubble on
	always_ff @(posedge clk) begin
		if (rst || taken || stall || stop) begin
			de_valid <= 1'b0;
		end else begin
			de_valid <= fd_valid;
		end
	end

	always_ff @(posedge clk) begin
		de_c <= dec_c;
		de_a <= read_out1;
		de_b <= ctrl.uses_rt ? read_out2 : '0;
		de_imm <= ctrl.imm_zero_ext ? {8'h00, fd_inst[7:0]} : {{8{fd_inst[7]}}, fd_inst[7:0]};
		de_pc <= fd_pc;
		de_jaddr <= fd_inst[11:0];
	end

	// execute to memory to write-back
	always_ff @(posedge clk) begin
		if (rst) begin
			em_valid <= 1'b0;
			mw_valid <= 1'b0;
		end else begin
			em_valid <= de_valid;
			mw_valid <= em_valid;
		end
	end

	always_ff @(posedge clk) begin
		em_c <= de_c;
		em_result <= alu_result;
		em_b <= de_b;
		em_link <= de_pc + 1'b1;
		mw_c <= em_c;
		mw_result <= em_result;
		mw_mem <= data_rdata;
		mw_link <= em_link;
	end

	always_comb begin
		case (mw_c.wb_sel)
			wb_mem: wb_data = mw_mem;
			wb_pc: wb_data = mw_link;
			wb_lhi: wb_data = {mw_result[7:0], 8'h00};
			default: wb_data = mw_result;
		endcase
	end

	assign wb_write = mw_valid && mw_c.reg_write;

	// retirement, output port and halt
	always_ff @(posedge clk) begin
		if (rst) begin
			num_inst <= '0;
			output_port <= '0;
			is_halted <= 1'b0;
		end else if (mw_valid) begin
			num_inst <= num_inst + 1'b1;
			if (mw_c.is_wwd) begin
				output_port <= mw_result;
			end
			if (mw_c.is_halt) begin
				is_halted <= 1'b1;
			end
		end
	end

	assign inst_read = !is_halted;
	assign inst_address = pc;
	assign decode_inst = fd_inst;
	assign data_read = em_valid && em_c.mem_read;
	assign data_write = em_valid && em_c.mem_write;
	assign data_address = em_result;
	assign data_wdata = em_b;
	assign output_valid = mw_valid && mw_c.is_wwd;

endmodule

// File: verilog/hazard_detect.sv
`timescale 1ns/1ns

module hazard_detect (
	input logic [1:0] rs,
	input logic [1:0] rt,
	input logic uses_rs,
	input logic uses_rt,
	input logic [1:0] dest_ex,
	input logic [1:0] dest_mem,
	input logic reg_write_ex,
	input logic reg_write_mem,
	output logic stall
);

	logic rs_busy;
	logic rt_busy;

	// writer in write-back is covered by the register file bypass
	assign rs_busy = (reg_write_ex && dest_ex == rs) || (reg_write_mem && dest_mem == rs);
	assign rt_busy = (reg_write_ex && dest_ex == rt) || (reg_write_mem && dest_mem == rt);

	assign stall = (uses_rs && rs_busy) || (uses_rt && rt_busy);

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ns

module register_file (
	input logic clk,
	input logic rst,
	input logic [1:0] read1,
	input logic [1:0] read2,
	output logic [cpu_pkg::word_size-1:0] read_out1,
	output logic [cpu_pkg::word_size-1:0] read_out2,
	input logic [1:0] dest,
	input logic [cpu_pkg::word_size-1:0] write_data,
	input logic reg_write
);
	import cpu_pkg::*;

	logic [word_size-1:0] regs [4];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else if (reg_write) begin
			regs[dest] <= write_data;
		end
	end

	// same-cycle write is visible to decode
	assign read_out1 = (reg_write && dest == read1) ? write_data : regs[read1];
	assign read_out2 = (reg_write && dest == read2) ? write_data : regs[read2];

endmodule
